// ==== hw/tcb_lite_config.svh ====
// bus and memory sizing for the TCB lite memory subsystem
// include wherever a width, the memory depth or the read delay is needed

`ifndef TCB_LITE_CONFIG_SVH
`define TCB_LITE_CONFIG_SVH

// word address width
`define TCB_ADR_W 10

// data width and matching byte enable width
`define TCB_DAT_W 32
`define TCB_BYT_W (`TCB_DAT_W/8)

// implemented words, addresses at or above this are out of range
`define TCB_MEM_DEPTH 256

// memory read delay in clock cycles
`define TCB_MEM_DLY 1

`endif

// ==== hw/tcb_lite_pkg.sv ====
// TCB lite bus types shared by the interface and every bus agent
// request and response payloads are packed structs sized from the config header

`include "tcb_lite_config.svh"

package tcb_lite_pkg;

    // basic field types
    typedef logic [`TCB_ADR_W-1:0] tcb_adr_t;
    typedef logic [`TCB_DAT_W-1:0] tcb_dat_t;
    typedef logic [`TCB_BYT_W-1:0] tcb_byt_t;

    //////////////////////////////////////////////////////////////////////
    // request, travels manager to subordinate with vld
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        // write enable, low for read
        logic     wen;
        tcb_adr_t adr;
        // byte enables, only used on writes
        tcb_byt_t byt;
        tcb_dat_t wdt;
    } tcb_req_t;

    //////////////////////////////////////////////////////////////////////
    // response, fixed delay after the request handshake
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        tcb_dat_t rdt;
        // access error, e.g. address out of range
        logic     err;
    } tcb_rsp_t;

endpackage

// ==== hw/rmw_cmd_pkg.sv ====
// command side types for the read-modify-write manager
// opcode encoding and the result returned at the top level

package rmw_cmd_pkg;

    // command opcodes
    // set and clear are read-modify-write on the addressed word
    typedef enum logic [1:0] {
        op_read  = 2'd0,
        op_write = 2'd1,
        op_set   = 2'd2,
        op_clear = 2'd3
    } rmw_op_e;

    // result of one command
    // rdt is read data, the old word for set/clear, zero for a write
    typedef struct packed {
        tcb_lite_pkg::tcb_dat_t rdt;
        logic                   err;
    } rmw_rsp_t;

endpackage

// ==== hw/tcb_lite_if.sv ====
// TCB lite bus segment between one manager and one subordinate
// valid/ready request handshake, response after a fixed delay with no stall

`timescale 1ns/1ps

interface tcb_lite_if (
    input logic clk,
    input logic rst_n
);

    // handshake
    logic                   vld;
    logic                   rdy;

    // payload
    tcb_lite_pkg::tcb_req_t req;
    tcb_lite_pkg::tcb_rsp_t rsp;

    // manager side, issues requests and samples responses
    modport man (
        input  clk,
        input  rst_n,
        output vld,
        output req,
        input  rdy,
        input  rsp
    );

    // subordinate side, accepts requests and returns responses
    modport sub (
        input  clk,
        input  rst_n,
        input  vld,
        input  req,
        output rdy,
        output rsp
    );

endinterface

// ==== hw/rmw_cmd_manager.sv ====
// command manager, turns top-level commands into TCB lite transfers
// read/write go straight to the bus, set/clear run as read then write
// responses are matched to requests with a fixed-delay flag line

`timescale 1ns/1ps
`include "tcb_lite_config.svh"

module rmw_cmd_manager (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cmd_vld,
    output logic                   cmd_rdy,
    input  rmw_cmd_pkg::rmw_op_e   cmd_op,
    input  tcb_lite_pkg::tcb_adr_t cmd_adr,
    input  tcb_lite_pkg::tcb_byt_t cmd_byt,
    input  tcb_lite_pkg::tcb_dat_t cmd_wdt,
    output logic                   rsp_vld,
    output rmw_cmd_pkg::rmw_rsp_t  rsp,
    tcb_lite_if.man                bus
);

    // response delay seen by this manager, memory plus one slice stage
    localparam int unsigned DLY = `TCB_MEM_DLY + 1;

    typedef enum logic [1:0] {
        idle,
        rmw_wait,
        rmw_write
    } state_e;

    state_e                 state;

    // in-flight flags, index 0 is the youngest
    logic [DLY-1:0]         dl_vld;
    logic [DLY-1:0]         dl_rpt;
    logic [DLY-1:0]         dl_rd;

    // captured read-modify-write command
    rmw_cmd_pkg::rmw_op_e   op_q;
    tcb_lite_pkg::tcb_adr_t adr_q;
    tcb_lite_pkg::tcb_byt_t byt_q;
    tcb_lite_pkg::tcb_dat_t wdt_q;
    tcb_lite_pkg::tcb_dat_t old_q;
    logic                   wr_pend;

    logic                   bus_hsk;
    logic                   cmd_rmw;
    logic                   lst_vld;
    logic                   lst_rpt;
    logic                   lst_rd;
    logic                   rd_ok;
    tcb_lite_pkg::tcb_dat_t old_wrd;
    tcb_lite_pkg::tcb_dat_t new_wrd;

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    assign bus_hsk = bus.vld & bus.rdy;
    assign cmd_rmw = (cmd_op == rmw_cmd_pkg::op_set) | (cmd_op == rmw_cmd_pkg::op_clear);

    // oldest entry lines up with the response on the bus
    assign lst_vld = dl_vld[DLY-1];
    assign lst_rpt = dl_rpt[DLY-1];
    assign lst_rd  = dl_rd[DLY-1];

    // rmw read came back clean, the write goes out this cycle
    assign rd_ok = (state == rmw_wait) & lst_vld & lst_rd & ~bus.rsp.err;

    // old word straight from the bus while waiting, then from the register
    assign old_wrd = (state == rmw_write) ? old_q : bus.rsp.rdt;
    assign new_wrd = (op_q == rmw_cmd_pkg::op_set) ? (old_wrd | wdt_q) : (old_wrd & ~wdt_q);

    // new commands only while idle, and only when the bus can take them
    assign cmd_rdy = (state == idle) & bus.rdy;

    //////////////////////////////////////////////////////////////////////
    // bus request
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        bus.vld     = 1'b0;
        bus.req.wen = 1'b1;
        bus.req.adr = adr_q;
        bus.req.byt = byt_q;
        bus.req.wdt = new_wrd;
        case (state)
            idle:
            begin
                // pass the command through, set/clear start as a read
                bus.vld     = cmd_vld;
                bus.req.wen = (cmd_op == rmw_cmd_pkg::op_write);
                bus.req.adr = cmd_adr;
                bus.req.byt = cmd_byt;
                bus.req.wdt = cmd_wdt;
            end
            rmw_wait:  bus.vld = rd_ok;
            rmw_write: bus.vld = wr_pend;
            default:   bus.vld = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // in-flight delay line and FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dl_vld  <= '0;
            dl_rpt  <= '0;
            dl_rd   <= '0;
            state   <= idle;
            wr_pend <= 1'b0;
        end
        else
        begin
            // the rmw read is the only transfer not reported directly
            dl_vld <= {dl_vld[DLY-2:0], bus_hsk};
            dl_rpt <= {dl_rpt[DLY-2:0], (state != idle) | ~cmd_rmw};
            dl_rd  <= {dl_rd[DLY-2:0], (state == idle) & cmd_rmw};
            case (state)
                idle:
                begin
                    if (cmd_vld & cmd_rdy & cmd_rmw)
                    begin
                        state <= rmw_wait;
                    end
                end
                rmw_wait:
                begin
                    // read error ends the command, it is reported now
                    if (lst_vld & lst_rd)
                    begin
                        state   <= bus.rsp.err ? idle : rmw_write;
                        wr_pend <= ~bus.rsp.err & ~bus.rdy;
                    end
                end
                rmw_write:
                begin
                    if (wr_pend & bus.rdy)
                    begin
                        wr_pend <= 1'b0;
                    end
                    // write response closes the command
                    if (lst_vld & lst_rpt)
                    begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // command capture and old word
    always_ff @(posedge clk)
    begin
        if ((state == idle) & cmd_vld & cmd_rdy)
        begin
            op_q  <= cmd_op;
            adr_q <= cmd_adr;
            byt_q <= cmd_byt;
            wdt_q <= cmd_wdt;
        end
        if (rd_ok)
        begin
            old_q <= bus.rsp.rdt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // top-level response
    //////////////////////////////////////////////////////////////////////

    // a failed rmw read is reported in place of the skipped write
    assign rsp_vld = lst_vld & (lst_rpt | (lst_rd & bus.rsp.err));
    assign rsp.rdt = old_wrd;
    assign rsp.err = bus.rsp.err;

endmodule

// ==== hw/tcb_lite_lib_register.sv ====
// TCB lite request register slice between two bus segments
// one entry, full throughput, adds one cycle to the request path
// responses pass back without delay

`timescale 1ns/1ps

module tcb_lite_lib_register (
    input  logic    clk,
    input  logic    rst_n,
    // upstream, the manager connects here
    tcb_lite_if.sub sub,
    // downstream, the subordinate connects here
    tcb_lite_if.man man
);

    // entry state
    logic                   full;
    tcb_lite_pkg::tcb_req_t req_q;

    logic                   up_hsk;
    logic                   dn_hsk;

    //////////////////////////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////////////////////////

    assign dn_hsk = man.vld & man.rdy;

    // free slot, or the entry leaves on this same cycle
    assign sub.rdy = ~full | man.rdy;
    assign up_hsk  = sub.vld & sub.rdy;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            full <= 1'b0;
        end
        else if (up_hsk)
        begin
            // refill, possibly while the old entry drains
            full <= 1'b1;
        end
        else if (dn_hsk)
        begin
            full <= 1'b0;
        end
    end

    // request payload
    always_ff @(posedge clk)
    begin
        if (up_hsk)
        begin
            req_q <= sub.req;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // downstream request and upstream response
    //////////////////////////////////////////////////////////////////////

    // back-pressure holds the entry in place
    assign man.vld = full;
    assign man.req = req_q;

    // response has no stall, so it goes straight back up
    assign sub.rsp = man.rsp;

endmodule

// ==== hw/tcb_lite_mem.sv ====
// byte-maskable SRAM subordinate on a TCB lite segment
// always ready, response registered one cycle after the request
// out-of-range accesses return err and leave the array unchanged

`timescale 1ns/1ps
`include "tcb_lite_config.svh"

module tcb_lite_mem (
    input  logic    clk,
    input  logic    rst_n,
    tcb_lite_if.sub bus
);

    localparam int unsigned IDX_W = $clog2(`TCB_MEM_DEPTH);

    // storage
    tcb_lite_pkg::tcb_dat_t mem [`TCB_MEM_DEPTH];

    logic                   hsk;
    logic                   in_rng;
    logic [IDX_W-1:0]       idx;

    // no wait states
    assign bus.rdy = 1'b1;

    assign hsk    = bus.vld & bus.rdy;
    assign in_rng = bus.req.adr < `TCB_ADR_W'(`TCB_MEM_DEPTH);
    assign idx    = bus.req.adr[IDX_W-1:0];

    //////////////////////////////////////////////////////////////////////
    // array write
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (hsk & in_rng & bus.req.wen)
        begin
            // only enabled bytes change
            for (int i = 0; i < `TCB_BYT_W; i++)
            begin
                if (bus.req.byt[i])
                begin
                    mem[idx][8*i +: 8] <= bus.req.wdt[8*i +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // registered response
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bus.rsp <= '0;
        end
        else if (hsk)
        begin
            // read data only for an in-range read, zero otherwise
            bus.rsp.rdt <= (in_rng & ~bus.req.wen) ? mem[idx] : '0;
            bus.rsp.err <= ~in_rng;
        end
    end

endmodule

// ==== hw/rmw_subsystem_top.sv ====
// memory subsystem top level with plain command and response ports
// chain is command manager, request register slice, SRAM subordinate

`timescale 1ns/1ps

module rmw_subsystem_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // command port
    input  logic                   cmd_vld,
    output logic                   cmd_rdy,
    input  rmw_cmd_pkg::rmw_op_e   cmd_op,
    input  tcb_lite_pkg::tcb_adr_t cmd_adr,
    input  tcb_lite_pkg::tcb_byt_t cmd_byt,
    input  tcb_lite_pkg::tcb_dat_t cmd_wdt,
    // response port, never stalled
    output logic                   rsp_vld,
    output tcb_lite_pkg::tcb_dat_t rsp_rdt,
    output logic                   rsp_err
);

    rmw_cmd_pkg::rmw_rsp_t rsp;

    // manager to slice, and slice to memory
    tcb_lite_if bus_mgr (.clk(clk), .rst_n(rst_n));
    tcb_lite_if bus_mem (.clk(clk), .rst_n(rst_n));

    rmw_cmd_manager i_manager (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd_vld (cmd_vld),
        .cmd_rdy (cmd_rdy),
        .cmd_op  (cmd_op),
        .cmd_adr (cmd_adr),
        .cmd_byt (cmd_byt),
        .cmd_wdt (cmd_wdt),
        .rsp_vld (rsp_vld),
        .rsp     (rsp),
        .bus     (bus_mgr)
    );

    tcb_lite_lib_register i_register (
        .clk   (clk),
        .rst_n (rst_n),
        .sub   (bus_mgr),
        .man   (bus_mem)
    );

    tcb_lite_mem i_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus_mem)
    );

    // result struct out as plain ports
    assign rsp_rdt = rsp.rdt;
    assign rsp_err = rsp.err;

endmodule

// ==== tests/rmw_subsystem_tb.sv ====
// directed testbench for the read-modify-write memory subsystem
// drives commands on the falling clock edge and checks every response
// against a reference memory model, latency and handshake flags

`timescale 1ns/1ps
`include "tcb_lite_config.svh"

module rmw_subsystem_tb;

    localparam int IDX_W      = $clog2(`TCB_MEM_DEPTH);
    localparam int TIMEOUT    = 20;
    localparam int STREAM_LEN = 32;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   cmd_vld;
    logic                   cmd_rdy;
    rmw_cmd_pkg::rmw_op_e   cmd_op;
    tcb_lite_pkg::tcb_adr_t cmd_adr;
    tcb_lite_pkg::tcb_byt_t cmd_byt;
    tcb_lite_pkg::tcb_dat_t cmd_wdt;
    logic                   rsp_vld;
    tcb_lite_pkg::tcb_dat_t rsp_rdt;
    logic                   rsp_err;

    // reference memory, LFSR state, cycle count and tallies
    tcb_lite_pkg::tcb_dat_t ref_mem [`TCB_MEM_DEPTH];
    logic [31:0]            lfsr = 32'hcb19_2d9e;
    int                     cyc = 0;
    int                     errors = 0;
    int                     tests_ok = 0;
    int                     tests_bad = 0;

    rmw_subsystem_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd_vld (cmd_vld),
        .cmd_rdy (cmd_rdy),
        .cmd_op  (cmd_op),
        .cmd_adr (cmd_adr),
        .cmd_byt (cmd_byt),
        .cmd_wdt (cmd_wdt),
        .rsp_vld (rsp_vld),
        .rsp_rdt (rsp_rdt),
        .rsp_err (rsp_err)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // rising edges seen so far, read on the falling edge
    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus and reference model
    //////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic tcb_lite_pkg::tcb_dat_t ref_word(input tcb_lite_pkg::tcb_adr_t a);
        return ref_mem[a[IDX_W-1:0]];
    endfunction

    // enabled bytes only, out-of-range writes are dropped
    function automatic void ref_write(input tcb_lite_pkg::tcb_adr_t a,
                                      input tcb_lite_pkg::tcb_byt_t byt,
                                      input tcb_lite_pkg::tcb_dat_t wdt);
        for (int i = 0; i < `TCB_BYT_W; i++)
        begin
            if (byt[i] && (int'(a) < `TCB_MEM_DEPTH))
            begin
                ref_mem[a[IDX_W-1:0]][8*i +: 8] = wdt[8*i +: 8];
            end
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_rsp(input tcb_lite_pkg::tcb_dat_t exp_rdt, input logic exp_err);
        if (rsp_rdt !== exp_rdt)
        begin
            $display("CHECK FAILED rsp_rdt got %h expected %h", rsp_rdt, exp_rdt);
            errors++;
        end
        if (rsp_err !== exp_err)
        begin
            $display("CHECK FAILED rsp_err got %h expected %h", rsp_err, exp_err);
            errors++;
        end
    endtask

    // cycles from command handshake to rsp_vld
    task automatic check_latency(input int got, input int exp);
        if (got != exp)
        begin
            $display("CHECK FAILED rsp_vld latency got %0h expected %0h", got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before)
        begin
            $display("test %s ok", name);
            tests_ok++;
        end
        else
        begin
            $display("test %s had %0d errors", name, errors - err_before);
            tests_bad++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // single command, called just after a falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic run_cmd(input rmw_cmd_pkg::rmw_op_e op, input tcb_lite_pkg::tcb_adr_t a,
                           input tcb_lite_pkg::tcb_byt_t byt,
                           input tcb_lite_pkg::tcb_dat_t wdt,
                           input tcb_lite_pkg::tcb_dat_t exp_rdt, input logic exp_err,
                           input int exp_lat);
        int   hs;
        int   n;
        logic rmw;
        rmw     = (op == rmw_cmd_pkg::op_set) || (op == rmw_cmd_pkg::op_clear);
        cmd_vld = 1'b1;
        cmd_op  = op;
        cmd_adr = a;
        cmd_byt = byt;
        cmd_wdt = wdt;
        n = 0;
        while (!cmd_rdy && (n < TIMEOUT))
        begin
            @(negedge clk);
            n++;
        end
        if (!cmd_rdy)
        begin
            $display("timeout, cmd_rdy never went high");
            errors++;
            cmd_vld = 1'b0;
        end
        else
        begin
            // handshake on the coming rising edge
            hs = cyc;
            @(negedge clk);
            cmd_vld = 1'b0;
            n = 0;
            while (!rsp_vld && (n < TIMEOUT))
            begin
                // set and clear keep the command port closed
                if (rmw)
                begin
                    check_flag("cmd_rdy", cmd_rdy, 1'b0);
                end
                @(negedge clk);
                n++;
            end
            if (!rsp_vld)
            begin
                $display("timeout, no response for the command");
                errors++;
            end
            else
            begin
                check_latency(cyc - hs, exp_lat);
                check_rsp(exp_rdt, exp_err);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        int e0;
        e0 = errors;
        check_flag("cmd_rdy", cmd_rdy, 1'b1);
        check_flag("rsp_vld", rsp_vld, 1'b0);
        report_test("reset", e0);
    endtask

    // every word gets a pattern built from its whole address
    task automatic init_memory();
        tcb_lite_pkg::tcb_adr_t a;
        for (int i = 0; i < `TCB_MEM_DEPTH; i++)
        begin
            a = tcb_lite_pkg::tcb_adr_t'(i);
            ref_mem[a[IDX_W-1:0]] = {~a[7:0], 8'h5a, 6'h00, a};
            run_cmd(rmw_cmd_pkg::op_write, a, '1, ref_word(a), '0, 1'b0, 2);
        end
    endtask

    task automatic test_byte_write();
        tcb_lite_pkg::tcb_adr_t adrs [4];
        tcb_lite_pkg::tcb_byt_t pats [4];
        tcb_lite_pkg::tcb_dat_t d;
        int                     e0;
        e0   = errors;
        pats = '{4'h1, 4'h6, 4'h8, 4'ha};
        for (int i = 0; i < 4; i++)
        begin
            adrs[i] = tcb_lite_pkg::tcb_adr_t'(rand_bits(IDX_W));
            d = rand_bits(32);
            ref_write(adrs[i], '1, d);
            run_cmd(rmw_cmd_pkg::op_write, adrs[i], '1, d, '0, 1'b0, 2);
        end
        // partial writes over the full ones
        for (int i = 0; i < 4; i++)
        begin
            d = rand_bits(32);
            ref_write(adrs[i], pats[i], d);
            run_cmd(rmw_cmd_pkg::op_write, adrs[i], pats[i], d, '0, 1'b0, 2);
        end
        for (int i = 0; i < 4; i++)
        begin
            run_cmd(rmw_cmd_pkg::op_read, adrs[i], '0, '0, ref_word(adrs[i]), 1'b0, 2);
        end
        report_test("byte_write", e0);
    endtask

    task automatic test_out_of_range();
        tcb_lite_pkg::tcb_adr_t a;
        tcb_lite_pkg::tcb_adr_t alias_adr;
        int                     e0;
        e0 = errors;
        a  = tcb_lite_pkg::tcb_adr_t'(`TCB_MEM_DEPTH) +
             tcb_lite_pkg::tcb_adr_t'(rand_bits(IDX_W));
        alias_adr = tcb_lite_pkg::tcb_adr_t'(a[IDX_W-1:0]);
        run_cmd(rmw_cmd_pkg::op_write, a, '1, 32'hdead_beef, '0, 1'b1, 2);
        run_cmd(rmw_cmd_pkg::op_read, a, '0, '0, '0, 1'b1, 2);
        run_cmd(rmw_cmd_pkg::op_read, '1, '0, '0, '0, 1'b1, 2);
        // low alias must be untouched
        run_cmd(rmw_cmd_pkg::op_read, alias_adr, '0, '0, ref_word(alias_adr), 1'b0, 2);
        report_test("out_of_range", e0);
    endtask

    task automatic test_set_clear();
        tcb_lite_pkg::tcb_adr_t a;
        tcb_lite_pkg::tcb_dat_t old;
        tcb_lite_pkg::tcb_dat_t m;
        int                     e0;
        e0  = errors;
        a   = tcb_lite_pkg::tcb_adr_t'(rand_bits(IDX_W));
        old = ref_word(a);
        m   = rand_bits(32);
        run_cmd(rmw_cmd_pkg::op_set, a, '1, m, old, 1'b0, 4);
        ref_write(a, '1, old | m);
        run_cmd(rmw_cmd_pkg::op_read, a, '0, '0, ref_word(a), 1'b0, 2);
        // clear on the low half only
        old = ref_word(a);
        m   = rand_bits(32);
        run_cmd(rmw_cmd_pkg::op_clear, a, 4'b0011, m, old, 1'b0, 4);
        ref_write(a, 4'b0011, old & ~m);
        run_cmd(rmw_cmd_pkg::op_read, a, '0, '0, ref_word(a), 1'b0, 2);
        report_test("set_clear", e0);
    endtask

    // one command per cycle, responses checked as they arrive
    task automatic test_stream();
        tcb_lite_pkg::tcb_dat_t exp_q [$];
        int                     hs_q [$];
        int                     e0;
        int                     issued;
        int                     got;
        int                     guard;
        logic                   pend;
        e0     = errors;
        issued = 0;
        got    = 0;
        guard  = 0;
        pend   = 1'b0;
        while ((got < STREAM_LEN) && (guard < STREAM_LEN + TIMEOUT))
        begin
            @(negedge clk);
            guard++;
            if (rsp_vld)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("response arrived with no command in flight");
                    errors++;
                end
                else
                begin
                    check_latency(cyc - hs_q.pop_front(), 2);
                    check_rsp(exp_q.pop_front(), 1'b0);
                    got++;
                end
            end
            if (!pend)
            begin
                cmd_vld = 1'b0;
                if (issued < STREAM_LEN)
                begin
                    cmd_vld = 1'b1;
                    cmd_op  = (rand_bits(1) == 32'd1) ? rmw_cmd_pkg::op_write :
                                                        rmw_cmd_pkg::op_read;
                    cmd_adr = tcb_lite_pkg::tcb_adr_t'(rand_bits(IDX_W));
                    cmd_byt = tcb_lite_pkg::tcb_byt_t'(rand_bits(`TCB_BYT_W));
                    cmd_wdt = rand_bits(32);
                    pend    = 1'b1;
                end
            end
            // accepted on the coming rising edge
            if (pend && cmd_rdy)
            begin
                hs_q.push_back(cyc);
                if (cmd_op == rmw_cmd_pkg::op_write)
                begin
                    exp_q.push_back('0);
                    ref_write(cmd_adr, cmd_byt, cmd_wdt);
                end
                else
                begin
                    exp_q.push_back(ref_word(cmd_adr));
                end
                issued++;
                pend = 1'b0;
            end
        end
        cmd_vld = 1'b0;
        if (got < STREAM_LEN)
        begin
            $display("timeout, stream got %0d of %0d responses", got, STREAM_LEN);
            errors++;
        end
        // nothing extra may follow
        repeat (3)
        begin
            @(negedge clk);
            check_flag("rsp_vld", rsp_vld, 1'b0);
        end
        report_test("stream", e0);
    endtask

    task automatic test_rmw_error();
        tcb_lite_pkg::tcb_adr_t a;
        tcb_lite_pkg::tcb_adr_t alias_adr;
        int                     e0;
        e0 = errors;
        a  = tcb_lite_pkg::tcb_adr_t'(`TCB_MEM_DEPTH) +
             tcb_lite_pkg::tcb_adr_t'(rand_bits(IDX_W));
        alias_adr = tcb_lite_pkg::tcb_adr_t'(a[IDX_W-1:0]);
        run_cmd(rmw_cmd_pkg::op_set, a, '1, 32'hffff_ffff, '0, 1'b1, 2);
        @(negedge clk);
        check_flag("cmd_rdy", cmd_rdy, 1'b1);
        run_cmd(rmw_cmd_pkg::op_read, alias_adr, '0, '0, ref_word(alias_adr), 1'b0, 2);
        report_test("rmw_error", e0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        rst_n   = 1'b0;
        cmd_vld = 1'b0;
        cmd_op  = rmw_cmd_pkg::op_read;
        cmd_adr = '0;
        cmd_byt = '0;
        cmd_wdt = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset();
        init_memory();
        test_byte_write();
        test_out_of_range();
        test_set_clear();
        test_stream();
        test_rmw_error();
        $display("summary: %0d tests ok, %0d tests with errors, %0d check errors",
                 tests_ok, tests_bad, errors);
        if (errors == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+hw
hw/tcb_lite_pkg.sv
hw/rmw_cmd_pkg.sv
hw/tcb_lite_if.sv
hw/rmw_cmd_manager.sv
hw/tcb_lite_lib_register.sv
hw/tcb_lite_mem.sv
hw/rmw_subsystem_top.sv
tests/rmw_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -f all.f \
        --top-module rmw_subsystem_tb -o rmw_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/rmw_sim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log

if grep -q "^Testbench passed$" sim.log; then
    exit 0
fi

echo "pass message not found in sim.log"
exit 1
